/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = acc_top_tb
FILELIST  = acc_top.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir

/* acc_top.f */
verilog/acc_pkg.sv
verilog/bias_ram.sv
verilog/acc_ram.sv
verilog/conv_acc.sv
verilog/scale.sv
verilog/max_pool.sv
verilog/acc_top.sv
verif/tb_clock.sv
verif/acc_top_tb.sv

/* bias.mem */
// one 132-bit word per line, six signed 22-bit lane biases
// lane 5 sits in the high bits, lane 0 in the low bits
000018000050000100000300000800001
fffffffffffffffffffffffffffffffff
000000000000000000000000000000000
004000010000040000100000400001000

/* verif/acc_top_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module acc_top_tb;
    import acc_pkg::*;

    localparam int NUM_JOBS    = 6;
    localparam int MAX_SIZE    = 16;
    localparam int PERIOD      = 20;
    localparam int DRIVE_DLY   = 2;
    localparam int DRAIN_LIMIT = 500;

    // job table with one column per field
    localparam int JOB_SIZE   [NUM_JOBS] = '{6, 5, 1, 4, 4, 9};
    localparam int JOB_PASSES [NUM_JOBS] = '{1, 3, 4, 1, 2, 2};
    localparam int JOB_BASE   [NUM_JOBS] = '{1, 3, 0, 1, 2, 0};
    localparam int JOB_SCALE  [NUM_JOBS] = '{3, 1, 7, 300, 40, 2};
    localparam int JOB_N      [NUM_JOBS] = '{4, 6, 6, 2, 3, 2};
    localparam int JOB_RELU   [NUM_JOBS] = '{0, 0, 0, 1, 2, 0};
    localparam int JOB_POOL_W [NUM_JOBS] = '{0, 0, 0, 0, 0, 3};

    logic                 clk;
    logic                 rst_n;
    logic [BUS_W-1:0]     acc_m_data;
    logic                 acc_m_first;
    logic                 acc_m_last;
    logic                 acc_m_valid;
    logic                 acc_m_ready;
    logic [INFO_W-1:0]    info_bus;
    logic [OUT_BUS_W-1:0] acc_s_data;
    logic                 acc_s_valid;
    logic                 acc_s_ready;

    logic [BUS_W-1:0]     bias_mem [BIAS_DEPTH];
    logic [BUS_W-1:0]     beat_q [$];
    logic [OUT_BUS_W-1:0] exp_q [$];
    int                   seed = 29;
    int                   ready_seed = 29;

    tb_clock clock_gen (
        .clk (clk)
    );

    acc_top acc_top_i (
        .acc_m_data  (acc_m_data),
        .acc_m_first (acc_m_first),
        .acc_m_last  (acc_m_last),
        .acc_m_valid (acc_m_valid),
        .acc_m_ready (acc_m_ready),
        .info_bus    (info_bus),
        .acc_s_data  (acc_s_data),
        .acc_s_valid (acc_s_valid),
        .acc_s_ready (acc_s_ready),
        .clk         (clk),
        .rst_n       (rst_n)
    );

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_out(input logic [OUT_BUS_W-1:0] got);
        logic [OUT_BUS_W-1:0] want;
        if (exp_q.size() == 0) begin
            stop_with_error($sformatf("the DUT sent an unexpected word %h at %0t ns",
                                      got, $time));
        end else begin
            want = exp_q.pop_front();
            if (got !== want) begin
                stop_with_error($sformatf("Mismatch at %0t ns: output word %h, expected %h",
                                          $time, got, want));
            end
        end
    endtask

    function automatic logic [INFO_W-1:0] build_info(input int j);
        logic [INFO_W-1:0] w;
        w = '0;
        w[SIZE_LSB +: SIZE_W]        = SIZE_W'(JOB_SIZE[j]);
        w[N_LSB +: N_W]              = N_W'(JOB_N[j]);
        w[BASE_LSB +: BIAS_ADDR_W]   = BIAS_ADDR_W'(JOB_BASE[j]);
        w[SCALE_LSB +: SCALE_W]      = SCALE_W'(JOB_SCALE[j]);
        w[RELU_LSB +: RELU_W]        = RELU_W'(JOB_RELU[j]);
        w[POOL_W_LSB +: POOL_W_W]    = POOL_W_W'(JOB_POOL_W[j]);
        w[POOL_EN_BIT]               = (JOB_POOL_W[j] != 0);
        return w;
    endfunction

    function automatic logic [BUS_W-1:0] random_beat();
        logic [BUS_W-1:0] w;
        int               v;
        for (int l = 0; l < LANES; l++) begin
            v = $random(seed) % 256;
            w[l*SUM_W +: SUM_W] = SUM_W'(v);
        end
        return w;
    endfunction

    // multiply, shift, rectify, then clip to signed 8 bits
    function automatic logic [OUT_W-1:0] expect_lane(input logic signed [SUM_W-1:0] sum,
                                                     input int j);
        longint v;
        v = longint'(sum) * longint'(JOB_SCALE[j]);
        v = v >>> JOB_N[j];
        if (v < 0) begin
            if ((JOB_RELU[j] & 1) != 0) begin
                v = 0;
            end else if ((JOB_RELU[j] & 2) != 0) begin
                v = v >>> 3;
            end
        end
        if (v > 127) begin
            return 8'h7f;
        end
        if (v < -128) begin
            return 8'h80;
        end
        return OUT_W'(v);
    endfunction

    task automatic prepare_job(input int j);
        logic signed [SUM_W-1:0] acc [MAX_SIZE][LANES];
        logic [OUT_BUS_W-1:0]    outs [MAX_SIZE];
        logic [OUT_BUS_W-1:0]    pooled;
        logic [BUS_W-1:0]        word;
        logic [BUS_W-1:0]        bias;
        int                      pw;
        bias = bias_mem[JOB_BASE[j]];
        beat_q.delete();
        for (int p = 0; p < JOB_SIZE[j]; p++) begin
            for (int l = 0; l < LANES; l++) begin
                acc[p][l] = bias[l*SUM_W +: SUM_W];
            end
        end
        for (int k = 0; k < JOB_PASSES[j]; k++) begin
            for (int p = 0; p < JOB_SIZE[j]; p++) begin
                word = random_beat();
                beat_q.push_back(word);
                for (int l = 0; l < LANES; l++) begin
                    acc[p][l] = acc[p][l] + word[l*SUM_W +: SUM_W];
                end
            end
        end
        for (int p = 0; p < JOB_SIZE[j]; p++) begin
            for (int l = 0; l < LANES; l++) begin
                outs[p][l*OUT_W +: OUT_W] = expect_lane(acc[p][l], j);
            end
        end
        pw = JOB_POOL_W[j];
        if (pw == 0) begin
            for (int p = 0; p < JOB_SIZE[j]; p++) begin
                exp_q.push_back(outs[p]);
            end
        end else begin
            for (int g = 0; g < JOB_SIZE[j]; g += pw) begin
                pooled = outs[g];
                for (int p = g + 1; p < g + pw; p++) begin
                    for (int l = 0; l < LANES; l++) begin
                        if ($signed(outs[p][l*OUT_W +: OUT_W]) >
                            $signed(pooled[l*OUT_W +: OUT_W])) begin
                            pooled[l*OUT_W +: OUT_W] = outs[p][l*OUT_W +: OUT_W];
                        end
                    end
                end
                exp_q.push_back(pooled);
            end
        end
    endtask

    // starts and ends just after a rising edge
    task automatic send_beat(input logic [BUS_W-1:0] data, input logic first,
                             input logic last);
        acc_m_data  = data;
        acc_m_first = first;
        acc_m_last  = last;
        acc_m_valid = 1'b1;
        @(negedge clk);
        while (!acc_m_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
        acc_m_valid = 1'b0;
    endtask

    task automatic send_job(input int j);
        int size;
        int passes;
        size   = JOB_SIZE[j];
        passes = JOB_PASSES[j];
        for (int k = 0; k < passes; k++) begin
            for (int p = 0; p < size; p++) begin
                send_beat(beat_q[k*size+p], k == 0, k == passes - 1);
            end
        end
    endtask

    task automatic drain_job(input int j);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            stop_with_error($sformatf("job %0d is missing %0d output words", j, exp_q.size()));
        end else begin
            // a duplicated word would show up here
            repeat (4) @(negedge clk);
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // valid and ready settle before the falling edge
    always @(negedge clk) begin
        if (rst_n && acc_s_valid && acc_s_ready) begin
            check_out(acc_s_data);
        end
    end

    initial begin : backpressure
        acc_s_ready = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            acc_s_ready = ($random(ready_seed) & 3) != 0;
        end
    end

    initial begin : watchdog
        int beats;
        beats = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            beats += JOB_SIZE[j] * JOB_PASSES[j];
        end
        #((beats * 40 + 200) * PERIOD);
        stop_with_error("timeout, the DUT stopped moving data");
    end

    initial begin : stimulus
        rst_n       = 1'b0;
        acc_m_data  = '0;
        acc_m_first = 1'b0;
        acc_m_last  = 1'b0;
        acc_m_valid = 1'b0;
        info_bus    = '0;
        $readmemh("bias.mem", bias_mem);
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        for (int j = 0; j < NUM_JOBS; j++) begin
            info_bus = build_info(j);
            prepare_job(j);
            send_job(j);
            drain_job(j);
        end
        if (exp_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_with_error($sformatf("%0d expected output words are missing", exp_q.size()));
        end
    end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* verilog/acc_pkg.sv */
`default_nettype none

package acc_pkg;

    // lane geometry
    localparam int LANES     = 6;
    localparam int SUM_W     = 22;
    localparam int BUS_W     = LANES * SUM_W;
    localparam int OUT_W     = 8;
    localparam int OUT_BUS_W = LANES * OUT_W;

    // memories
    localparam int ADDR_W      = 10;
    localparam int BIAS_ADDR_W = 9;
    localparam int ACC_DEPTH   = 1 << ADDR_W;
    localparam int BIAS_DEPTH  = 1 << BIAS_ADDR_W;

    localparam int SCALE_W = 9;

    // info word layout
    localparam int INFO_W      = 46;
    localparam int N_LSB       = 3;
    localparam int N_W         = 5;
    localparam int SIZE_LSB    = 8;
    localparam int SIZE_W      = 9;
    localparam int BASE_LSB    = 17;
    localparam int SCALE_LSB   = 26;
    localparam int RELU_LSB    = 37;
    localparam int RELU_W      = 2;
    localparam int POOL_W_LSB  = 39;
    localparam int POOL_W_W    = 6;
    localparam int POOL_EN_BIT = 45;

endpackage

`default_nettype wire

/* verilog/acc_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module acc_ram (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [acc_pkg::ADDR_W-1:0] rd_addr,
    input  logic                       rd_en,
    output logic [acc_pkg::BUS_W-1:0]  rd_data,
    input  logic [acc_pkg::ADDR_W-1:0] wr_addr,
    input  logic                       wr_en,
    input  logic [acc_pkg::BUS_W-1:0]  wr_data
);
    import acc_pkg::*;

    logic [BUS_W-1:0] mem [ACC_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // a write in the same cycle is not seen here, conv_acc forwards it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/acc_top.sv */
`timescale 1ns/1ns
`default_nettype none

module acc_top (
    input  logic [acc_pkg::BUS_W-1:0]     acc_m_data,
    input  logic                          acc_m_first,
    input  logic                          acc_m_last,
    input  logic                          acc_m_valid,
    output logic                          acc_m_ready,
    input  logic [acc_pkg::INFO_W-1:0]    info_bus,
    output logic [acc_pkg::OUT_BUS_W-1:0] acc_s_data,
    output logic                          acc_s_valid,
    input  logic                          acc_s_ready,
    input  logic                          clk,
    input  logic                          rst_n
);
    import acc_pkg::*;

    logic [BIAS_ADDR_W-1:0] base;
    logic [SIZE_W-1:0]      size;
    logic [N_W-1:0]         n;
    logic [SCALE_W-1:0]     scale_factor;
    logic [RELU_W-1:0]      relu_en;
    logic [POOL_W_W-1:0]    pool_width;
    logic                   pool_en;

    logic [BIAS_ADDR_W-1:0] bias_addr;
    logic                   bias_rd_en;
    logic [BUS_W-1:0]       bias_data;
    logic [ADDR_W-1:0]      ram_rd_addr;
    logic                   ram_rd_en;
    logic [BUS_W-1:0]       ram_rd_data;
    logic [ADDR_W-1:0]      ram_wr_addr;
    logic                   ram_wr_en;
    logic [BUS_W-1:0]       ram_wr_data;

    logic [BUS_W-1:0]       final_sum;
    logic                   final_valid;
    logic                   final_ready;
    logic [OUT_BUS_W-1:0]   scaled;
    logic                   scaled_valid;
    logic                   scaled_ready;

    // static job configuration
    assign base         = info_bus[BASE_LSB +: BIAS_ADDR_W];
    assign size         = info_bus[SIZE_LSB +: SIZE_W];
    assign n            = info_bus[N_LSB +: N_W];
    assign scale_factor = info_bus[SCALE_LSB +: SCALE_W];
    assign relu_en      = info_bus[RELU_LSB +: RELU_W];
    assign pool_width   = info_bus[POOL_W_LSB +: POOL_W_W];
    assign pool_en      = info_bus[POOL_EN_BIT];

    bias_ram i_bias_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (bias_addr),
        .rd_en (bias_rd_en),
        .data  (bias_data)
    );

    conv_acc i_conv_acc (
        .clk         (clk),
        .rst_n       (rst_n),
        .m_data      (acc_m_data),
        .m_first     (acc_m_first),
        .m_last      (acc_m_last),
        .m_valid     (acc_m_valid),
        .m_ready     (acc_m_ready),
        .base        (base),
        .size        (size),
        .bias_addr   (bias_addr),
        .bias_rd_en  (bias_rd_en),
        .bias_data   (bias_data),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_en   (ram_rd_en),
        .ram_rd_data (ram_rd_data),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_data (ram_wr_data),
        .s_sum       (final_sum),
        .s_valid     (final_valid),
        .s_ready     (final_ready)
    );

    acc_ram i_acc_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_addr (ram_rd_addr),
        .rd_en   (ram_rd_en),
        .rd_data (ram_rd_data),
        .wr_addr (ram_wr_addr),
        .wr_en   (ram_wr_en),
        .wr_data (ram_wr_data)
    );

    scale i_scale (
        .clk          (clk),
        .rst_n        (rst_n),
        .m_data       (final_sum),
        .m_valid      (final_valid),
        .m_ready      (final_ready),
        .scale_factor (scale_factor),
        .n            (n),
        .relu_en      (relu_en),
        .s_data       (scaled),
        .s_valid      (scaled_valid),
        .s_ready      (scaled_ready)
    );

    max_pool i_max_pool (
        .clk        (clk),
        .rst_n      (rst_n),
        .m_data     (scaled),
        .m_valid    (scaled_valid),
        .m_ready    (scaled_ready),
        .pool_width (pool_width),
        .pool_en    (pool_en),
        .s_data     (acc_s_data),
        .s_valid    (acc_s_valid),
        .s_ready    (acc_s_ready)
    );

endmodule

`default_nettype wire

/* verilog/bias_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module bias_ram (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [acc_pkg::BIAS_ADDR_W-1:0] addr,
    input  logic                            rd_en,
    output logic [acc_pkg::BUS_W-1:0]       data
);
    import acc_pkg::*;

    // six lane biases per word, lane 0 in the low bits
    logic [BUS_W-1:0] mem [BIAS_DEPTH];

    initial begin
        $readmemh("bias.mem", mem);
    end

    // read register holds while the pipeline is stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data <= '0;
        end else if (rd_en) begin
            data <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/conv_acc.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_acc (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [acc_pkg::BUS_W-1:0]       m_data,
    input  logic                            m_first,
    input  logic                            m_last,
    input  logic                            m_valid,
    output logic                            m_ready,
    input  logic [acc_pkg::BIAS_ADDR_W-1:0] base,
    input  logic [acc_pkg::SIZE_W-1:0]      size,
    output logic [acc_pkg::BIAS_ADDR_W-1:0] bias_addr,
    output logic                            bias_rd_en,
    input  logic [acc_pkg::BUS_W-1:0]       bias_data,
    output logic [acc_pkg::ADDR_W-1:0]      ram_rd_addr,
    output logic                            ram_rd_en,
    input  logic [acc_pkg::BUS_W-1:0]       ram_rd_data,
    output logic [acc_pkg::ADDR_W-1:0]      ram_wr_addr,
    output logic                            ram_wr_en,
    output logic [acc_pkg::BUS_W-1:0]       ram_wr_data,
    output logic [acc_pkg::BUS_W-1:0]       s_sum,
    output logic                            s_valid,
    input  logic                            s_ready
);
    import acc_pkg::*;

    logic [ADDR_W-1:0] pos;
    logic              m_fire;

    logic              s1_valid;
    logic              s1_first;
    logic              s1_last;
    logic [BUS_W-1:0]  s1_data;
    logic [ADDR_W-1:0] s1_addr;
    logic              s1_fire;

    logic              s2_valid;
    logic              s2_first;
    logic              s2_last;
    logic [BUS_W-1:0]  s2_data;
    logic [ADDR_W-1:0] s2_addr;
    logic              s2_fire;
    logic              s2_ready;
    logic [BUS_W-1:0]  operand;
    logic [BUS_W-1:0]  s2_sum;
    logic              s_load;

    logic              fwd_valid;
    logic [ADDR_W-1:0] fwd_addr;
    logic [BUS_W-1:0]  fwd_sum;

    // non-last items retire into the ram without the output register
    assign s2_fire  = s2_valid && (!s2_last || !s_valid || s_ready);
    assign s2_ready = !s2_valid || s2_fire;
    assign s1_fire  = s1_valid && s2_ready;
    assign m_ready  = !s1_valid || s2_ready;
    assign m_fire   = m_valid && m_ready;

    assign bias_addr   = base;
    assign bias_rd_en  = s1_fire && s1_first;
    assign ram_rd_addr = s1_addr;
    assign ram_rd_en   = s1_fire && !s1_first;

    // last write may land on the same edge as this item's read
    assign operand = s2_first ? bias_data :
                     (fwd_valid && fwd_addr == s2_addr) ? fwd_sum : ram_rd_data;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            s2_sum[i*SUM_W +: SUM_W] = s2_data[i*SUM_W +: SUM_W] + operand[i*SUM_W +: SUM_W];
        end
    end

    assign ram_wr_en   = s2_fire && !s2_last;
    assign ram_wr_addr = s2_addr;
    assign ram_wr_data = s2_sum;
    assign s_load      = s2_fire && s2_last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pos       <= '0;
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            s_valid   <= 1'b0;
            fwd_valid <= 1'b0;
        end else begin
            if (m_fire) begin
                pos <= (pos == ADDR_W'(size) - 1'b1) ? '0 : pos + 1'b1;
            end
            if (m_fire) begin
                s1_valid <= 1'b1;
            end else if (s1_fire) begin
                s1_valid <= 1'b0;
            end
            if (s1_fire) begin
                s2_valid <= 1'b1;
            end else if (s2_fire) begin
                s2_valid <= 1'b0;
            end
            if (s_load) begin
                s_valid <= 1'b1;
            end else if (s_ready) begin
                s_valid <= 1'b0;
            end
            if (ram_wr_en) begin
                fwd_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (m_fire) begin
            s1_data  <= m_data;
            s1_first <= m_first;
            s1_last  <= m_last;
            s1_addr  <= pos;
        end
        if (s1_fire) begin
            s2_data  <= s1_data;
            s2_first <= s1_first;
            s2_last  <= s1_last;
            s2_addr  <= s1_addr;
        end
        if (ram_wr_en) begin
            fwd_addr <= s2_addr;
            fwd_sum  <= s2_sum;
        end
        if (s_load) begin
            s_sum <= s2_sum;
        end
    end

    a_size_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid |-> size != '0);

    // size stays put while a job runs
    a_pos_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid |-> pos < ADDR_W'(size));

endmodule

`default_nettype wire

/* verilog/max_pool.sv */
`timescale 1ns/1ns
`default_nettype none

module max_pool (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [acc_pkg::OUT_BUS_W-1:0] m_data,
    input  logic                          m_valid,
    output logic                          m_ready,
    input  logic [acc_pkg::POOL_W_W-1:0]  pool_width,
    input  logic                          pool_en,
    output logic [acc_pkg::OUT_BUS_W-1:0] s_data,
    output logic                          s_valid,
    input  logic                          s_ready
);
    import acc_pkg::*;

    logic [OUT_BUS_W-1:0] run_max;
    logic [OUT_BUS_W-1:0] merged;
    logic [POOL_W_W-1:0]  cnt;
    logic                 m_fire;
    logic                 group_end;
    logic                 s_load;

    assign m_ready   = !s_valid || s_ready;
    assign m_fire    = m_valid && m_ready;
    assign group_end = (cnt == pool_width - 1'b1);
    assign s_load    = m_fire && (!pool_en || group_end);

    // first beat of a group starts the maximum afresh
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (cnt == '0 ||
                $signed(m_data[i*OUT_W +: OUT_W]) > $signed(run_max[i*OUT_W +: OUT_W])) begin
                merged[i*OUT_W +: OUT_W] = m_data[i*OUT_W +: OUT_W];
            end else begin
                merged[i*OUT_W +: OUT_W] = run_max[i*OUT_W +: OUT_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt     <= '0;
            s_valid <= 1'b0;
        end else begin
            if (m_fire && pool_en) begin
                cnt <= group_end ? '0 : cnt + 1'b1;
            end
            if (s_load) begin
                s_valid <= 1'b1;
            end else if (s_ready) begin
                s_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (m_fire) begin
            run_max <= merged;
        end
        if (s_load) begin
            s_data <= pool_en ? merged : m_data;
        end
    end

    a_width_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        pool_en |-> pool_width != '0);

    // pool_width stays put inside a group
    a_cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        pool_en |-> cnt < pool_width);

endmodule

`default_nettype wire

/* verilog/scale.sv */
`timescale 1ns/1ns
`default_nettype none

module scale (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [acc_pkg::BUS_W-1:0]     m_data,
    input  logic                          m_valid,
    output logic                          m_ready,
    input  logic [acc_pkg::SCALE_W-1:0]   scale_factor,
    input  logic [acc_pkg::N_W-1:0]       n,
    input  logic [acc_pkg::RELU_W-1:0]    relu_en,
    output logic [acc_pkg::OUT_BUS_W-1:0] s_data,
    output logic                          s_valid,
    input  logic                          s_ready
);
    import acc_pkg::*;

    logic [OUT_BUS_W-1:0] lane_out;
    logic                 m_fire;

    assign m_ready = !s_valid || s_ready;
    assign m_fire  = m_valid && m_ready;

    always_comb begin
        logic signed [SUM_W+SCALE_W:0] prod;
        logic signed [SUM_W+SCALE_W:0] act;
        for (int i = 0; i < LANES; i++) begin
            // scale factor is unsigned, widen before the signed multiply
            prod = $signed(m_data[i*SUM_W +: SUM_W]) * $signed({1'b0, scale_factor});
            act  = prod >>> n;
            if (act < 0) begin
                if (relu_en[0]) begin
                    act = '0;
                end else if (relu_en[1]) begin
                    // leaky slope of 1/8
                    act = act >>> 3;
                end
            end
            if (act > 127) begin
                lane_out[i*OUT_W +: OUT_W] = 8'h7f;
            end else if (act < -128) begin
                lane_out[i*OUT_W +: OUT_W] = 8'h80;
            end else begin
                lane_out[i*OUT_W +: OUT_W] = act[OUT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_valid <= 1'b0;
        end else if (m_fire) begin
            s_valid <= 1'b1;
        end else if (s_ready) begin
            s_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (m_fire) begin
            s_data <= lane_out;
        end
    end

endmodule

`default_nettype wire
